//--- acoustics_pkg.sv
`default_nettype none

package acoustics_pkg;

	// ----------------------------------------------------------
	// Data widths
	// ----------------------------------------------------------
	parameter int SAMPLE_BITS     = 24;                    // Bits per ADC sample
	parameter int CHANNELS        = 4;                     // ADCs read in parallel
	parameter int FRAME_BITS      = 128;                   // One stored frame
	parameter int PIPE_BITS       = 32;                    // One host pipe word
	parameter int WORDS_PER_FRAME = FRAME_BITS / PIPE_BITS; // Pipe words per frame

	typedef logic [SAMPLE_BITS-1:0] sample_t;              // One channel sample
	typedef logic [FRAME_BITS-1:0]  frame_t;               // Packed frame
	typedef logic [PIPE_BITS-1:0]   pipe_word_t;           // Host word

	// ----------------------------------------------------------
	// Frame layout with channel index 0 highest below the pad
	// ----------------------------------------------------------
	parameter int CH_PF = 0;                               // Bits 95..72
	parameter int CH_PA = 1;                               // Bits 71..48
	parameter int CH_SF = 2;                               // Bits 47..24
	parameter int CH_SA = 3;                               // Bits 23..0

	// Lowest frame bit of a channel slot
	function automatic int ch_lsb(input int ch);
		return (CHANNELS - 1 - ch) * SAMPLE_BITS;
	endfunction

endpackage

`default_nettype wire

//--- sample_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sample_fifo import acoustics_pkg::*; #(
	parameter type payload_t = pipe_word_t,            // Entry type
	parameter int  DEPTH     = 8                       // Number of entries
) (
	input  wire                           okClk,
	input  wire                           reset_sclk,
	input  wire                           clear,       // Empties the FIFO
	input  wire                           push,
	input  payload_t                      push_data,
	input  wire                           pop,
	output payload_t                      pop_data,    // Head entry, valid when not empty
	output logic [$clog2(DEPTH + 1)-1:0]  count,       // Fill level
	output logic                          empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t        mem [DEPTH];                      // Storage array
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic            push_ok;
	logic            pop_ok;

	assign empty   = (count == '0);
	assign push_ok = push && (count != CW'(DEPTH));   // Full drops the write
	assign pop_ok  = pop && !empty;                   // Empty ignores the pop

	assign pop_data = mem[rd_ptr];                    // First word fall through

	always_ff @(posedge okClk) begin
		if (push_ok) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// ----------------------------------------------------------
	// Pointers and fill count
	// ----------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (reset_sclk || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap
			end
			if (pop_ok) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;               // Both or neither
			endcase
		end
	end

	a_no_pop_empty: assert property (@(posedge okClk) disable iff (reset_sclk || clear)
		pop |-> !empty)
		else $error("pop while FIFO empty");

	a_count_bound: assert property (@(posedge okClk) disable iff (reset_sclk)
		count <= CW'(DEPTH))
		else $error("FIFO count above depth");

endmodule

`default_nettype wire

//--- adc_capture.sv
`timescale 1ns/100ps
`default_nettype none

module adc_capture import acoustics_pkg::*; #(
	parameter int SCLK_HALF = 2                        // okClk cycles per sclk half period
) (
	input  wire    okClk,
	input  wire    reset_sclk,
	input  wire    clear,                              // Host clear acts as a reset
	input  wire    drdy_in,                            // Falls when ADCs hold a sample
	input  wire    miso_pf_in,
	input  wire    miso_pa_in,
	input  wire    miso_sf_in,
	input  wire    miso_sa_in,
	output logic   sclk_out,                           // Bit request, ADC shifts on rise
	output frame_t frame,                              // Completed frame
	output logic   frame_valid                         // One-cycle frame strobe
);

	localparam int HALF_W = $clog2(SCLK_HALF + 1);
	localparam int BIT_W  = $clog2(SAMPLE_BITS + 1);

	logic              drdy_meta;                      // Synchronizer stage 1
	logic              drdy_sync;                      // Synchronizer stage 2
	logic              drdy_prev;                      // Edge detect history
	logic              drdy_fall;
	logic              busy;                           // Transfer in progress
	logic [HALF_W-1:0] half_cnt;                       // sclk divider
	logic [BIT_W-1:0]  bit_cnt;                        // Bits taken so far
	logic              half_done;
	logic              sclk_fall;
	logic [CHANNELS-1:0] miso;
	sample_t           shift_q [CHANNELS];             // Per-channel shift registers

	assign miso[CH_PF] = miso_pf_in;
	assign miso[CH_PA] = miso_pa_in;
	assign miso[CH_SF] = miso_sf_in;
	assign miso[CH_SA] = miso_sa_in;

	// ----------------------------------------------------------
	// drdy synchronizer and falling edge
	// ----------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (reset_sclk) begin
			drdy_meta <= 1'b1;                         // drdy idles high
			drdy_sync <= 1'b1;
			drdy_prev <= 1'b1;
		end else begin
			drdy_meta <= drdy_in;
			drdy_sync <= drdy_meta;
			drdy_prev <= drdy_sync;
		end
	end

	assign drdy_fall = drdy_prev & ~drdy_sync;

	// ----------------------------------------------------------
	// Transfer control
	// ----------------------------------------------------------
	assign half_done = busy && (half_cnt == HALF_W'(SCLK_HALF - 1));
	assign sclk_fall = half_done && sclk_out;           // sclk about to go low

	always_ff @(posedge okClk) begin
		if (reset_sclk || clear) begin
			busy        <= 1'b0;
			sclk_out    <= 1'b0;
			half_cnt    <= '0;
			bit_cnt     <= '0;
			frame_valid <= 1'b0;
		end else begin
			frame_valid <= 1'b0;                       // Low unless a frame completes
			if (!busy) begin
				if (drdy_fall) begin                   // Falls mid-transfer never get here
					busy     <= 1'b1;
					sclk_out <= 1'b1;                  // First half is high
					half_cnt <= '0;
					bit_cnt  <= '0;
				end
			end else if (half_done) begin
				half_cnt <= '0;
				sclk_out <= ~sclk_out;
				if (sclk_fall) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == BIT_W'(SAMPLE_BITS - 1)) begin
						busy        <= 1'b0;           // Last bit taken
						frame_valid <= 1'b1;
					end
				end
			end else begin
				half_cnt <= half_cnt + 1'b1;
			end
		end
	end

	// Data taken on the okClk edge where sclk falls
	always_ff @(posedge okClk) begin
		if (sclk_fall) begin
			for (int i = 0; i < CHANNELS; i++) begin
				shift_q[i] <= {shift_q[i][SAMPLE_BITS-2:0], miso[i]}; // MSB first
			end
		end
	end

	// Place samples into the frame slots below a zero pad
	always_comb begin
		frame = '0;
		for (int i = 0; i < CHANNELS; i++) begin
			frame[ch_lsb(i) +: SAMPLE_BITS] = shift_q[i];
		end
	end

	a_single_valid: assert property (@(posedge okClk) disable iff (reset_sclk)
		frame_valid |=> !frame_valid)
		else $error("frame_valid held for two cycles");

endmodule

`default_nettype wire

//--- frame_unpacker.sv
`timescale 1ns/100ps
`default_nettype none

module frame_unpacker import acoustics_pkg::*; #(
	parameter int RECALL_DEPTH = 1024                   // Sets recall_free width
) (
	input  wire                                  okClk,
	input  wire                                  reset_sclk,
	input  wire                                  clear,
	input  wire                                  read_en,      // Host read enable
	input  wire                                  frame_empty,  // Storage FIFO empty
	input  frame_t                               frame,        // Storage FIFO head
	output logic                                 frame_pop,
	input  wire [$clog2(RECALL_DEPTH + 1)-1:0]   recall_free,  // Free recall entries
	output pipe_word_t                           word,
	output logic                                 word_valid
);

	localparam int IW = $clog2(WORDS_PER_FRAME);

	frame_t        frame_q;                             // Frame being split
	logic [IW-1:0] word_idx;                            // Slice in flight
	logic          busy;

	// Pop only with room for a whole frame of words
	assign frame_pop = read_en && !busy && !frame_empty &&
		(recall_free >= WORDS_PER_FRAME);

	assign word_valid = busy;
	assign word       = frame_q[word_idx*PIPE_BITS +: PIPE_BITS]; // Low slice first

	always_ff @(posedge okClk) begin
		if (frame_pop) begin
			frame_q <= frame;
		end
	end

	always_ff @(posedge okClk) begin
		if (reset_sclk || clear) begin
			busy     <= 1'b0;
			word_idx <= '0;
		end else if (frame_pop) begin
			busy     <= 1'b1;                           // Words start next cycle
			word_idx <= '0;
		end else if (busy) begin
			word_idx <= word_idx + 1'b1;
			if (word_idx == IW'(WORDS_PER_FRAME - 1)) begin
				busy <= 1'b0;                           // Next pop allowed now
			end
		end
	end

	a_room_for_word: assert property (@(posedge okClk) disable iff (reset_sclk || clear)
		word_valid |-> (recall_free != '0))
		else $error("word issued with recall FIFO full");

endmodule

`default_nettype wire

//--- pipe_out_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_out_buffer import acoustics_pkg::*; #(
	parameter int RECALL_DEPTH = 1024,                  // Recall FIFO entries
	parameter int BLOCK_WORDS  = 128                    // Words per host block
) (
	input  wire                                  okClk,
	input  wire                                  reset_sclk,
	input  wire                                  clear,
	input  pipe_word_t                           word,
	input  wire                                  word_valid,
	output logic [$clog2(RECALL_DEPTH + 1)-1:0]  recall_free,  // Room left
	input  wire                                  pipe_read,    // Host read strobe
	output pipe_word_t                           pipe_data,
	output logic                                 pipe_ready    // Block waiting
);

	localparam int CW = $clog2(RECALL_DEPTH + 1);

	logic [CW-1:0] recall_count;

	sample_fifo #(
		.payload_t (pipe_word_t),
		.DEPTH     (RECALL_DEPTH)
	) recall_fifo (
		.okClk      (okClk),
		.reset_sclk (reset_sclk),
		.clear      (clear),
		.push       (word_valid),
		.push_data  (word),
		.pop        (pipe_read),                        // Host strobe pops head
		.pop_data   (pipe_data),
		.count      (recall_count),
		.empty      ()
	);

	assign recall_free = CW'(RECALL_DEPTH) - recall_count;

	// Host may start a block transfer
	always_ff @(posedge okClk) begin
		if (reset_sclk || clear) begin
			pipe_ready <= 1'b0;
		end else begin
			pipe_ready <= (recall_count >= CW'(BLOCK_WORDS));
		end
	end

endmodule

`default_nettype wire

//--- acoustics_top.sv
`timescale 1ns/100ps
`default_nettype none

module acoustics_top import acoustics_pkg::*; #(
	parameter int SCLK_HALF    = 2,                     // okClk cycles per sclk half
	parameter int STORE_DEPTH  = 256,                   // Frames in storage FIFO
	parameter int RECALL_DEPTH = 1024,                  // Words in recall FIFO
	parameter int BLOCK_WORDS  = 128                    // Words per host block
) (
	input  wire        okClk,
	input  wire        reset_sclk,
	input  wire        collect_en,                      // Host collect level
	input  wire        read_en,                         // Host read level
	input  wire        clear,                           // Host clear level
	input  wire        drdy_in,
	input  wire        miso_pf_in,
	input  wire        miso_pa_in,
	input  wire        miso_sf_in,
	input  wire        miso_sa_in,
	output logic       sclk_out,
	output logic       start,                           // ADC runs while high
	input  wire        pipe_read,
	output pipe_word_t pipe_data,
	output logic       pipe_ready
);

	localparam int FREE_W = $clog2(RECALL_DEPTH + 1);

	frame_t            cap_frame;
	logic              cap_valid;
	frame_t            store_head;
	logic              store_pop;
	logic              store_empty;
	logic [FREE_W-1:0] recall_free;
	pipe_word_t        unpack_word;
	logic              unpack_valid;

	assign start = collect_en;

	// ----------------------------------------------------------
	// Capture into storage FIFO
	// ----------------------------------------------------------
	adc_capture #(.SCLK_HALF(SCLK_HALF)) u_capture (
		.okClk(okClk), .reset_sclk(reset_sclk), .clear(clear), .drdy_in(drdy_in),
		.miso_pf_in(miso_pf_in), .miso_pa_in(miso_pa_in),
		.miso_sf_in(miso_sf_in), .miso_sa_in(miso_sa_in),
		.sclk_out(sclk_out), .frame(cap_frame), .frame_valid(cap_valid)
	);

	sample_fifo #(.payload_t(frame_t), .DEPTH(STORE_DEPTH)) store_fifo (
		.okClk(okClk), .reset_sclk(reset_sclk), .clear(clear),
		.push(cap_valid), .push_data(cap_frame),    // Full drops the frame
		.pop(store_pop), .pop_data(store_head),
		.count(), .empty(store_empty)
	);

	// ----------------------------------------------------------
	// Split frames and buffer for the host
	// ----------------------------------------------------------
	frame_unpacker #(.RECALL_DEPTH(RECALL_DEPTH)) u_unpacker (
		.okClk(okClk), .reset_sclk(reset_sclk), .clear(clear), .read_en(read_en),
		.frame_empty(store_empty), .frame(store_head), .frame_pop(store_pop),
		.recall_free(recall_free), .word(unpack_word), .word_valid(unpack_valid)
	);

	pipe_out_buffer #(.RECALL_DEPTH(RECALL_DEPTH), .BLOCK_WORDS(BLOCK_WORDS)) u_pipe (
		.okClk(okClk), .reset_sclk(reset_sclk), .clear(clear),
		.word(unpack_word), .word_valid(unpack_valid), .recall_free(recall_free),
		.pipe_read(pipe_read), .pipe_data(pipe_data), .pipe_ready(pipe_ready)
	);

endmodule

`default_nettype wire

//--- tb_acoustics.sv
`timescale 1ns/100ps
`default_nettype none

module tb_acoustics import acoustics_pkg::*; ();

	localparam int SCLK_HALF    = 2;
	localparam int STORE_DEPTH  = 8;
	localparam int RECALL_DEPTH = 32;
	localparam int BLOCK_WORDS  = 8;
	localparam int ROWS         = 9;
	localparam int MODE_PLAIN   = 0;                    // Normal capture
	localparam int MODE_GLITCH  = 1;                    // Extra drdy fall mid-transfer
	localparam int MODE_CLEAR   = 2;                    // Clear after capture
	localparam int WATCH_CYCLES = ROWS * (60 * SCLK_HALF + 20) + 2000;

	logic       okClk = 1'b0;
	logic       reset_sclk = 1'b1;                      // Held from time zero
	logic       collect_en = 1'b0;
	logic       read_en = 1'b0;
	logic       clear = 1'b0;
	logic       drdy_in = 1'b1;                         // drdy idles high
	logic       miso_pf_in = 1'b0;
	logic       miso_pa_in = 1'b0;
	logic       miso_sf_in = 1'b0;
	logic       miso_sa_in = 1'b0;
	logic       pipe_read = 1'b0;
	logic       sclk_out;
	logic       start;
	pipe_word_t pipe_data;
	logic       pipe_ready;

	sample_t    tab_pf [ROWS];                          // Stimulus table
	sample_t    tab_pa [ROWS];
	sample_t    tab_sf [ROWS];
	sample_t    tab_sa [ROWS];
	int         tab_mode [ROWS];
	bit         tab_read [ROWS];                        // Read a block after this row
	sample_t    cur_pf = '0;                            // Sample the ADCs hold now
	sample_t    cur_pa = '0;
	sample_t    cur_sf = '0;
	sample_t    cur_sa = '0;
	logic       sclk_d = 1'b0;
	int         bit_idx = SAMPLE_BITS - 1;
	integer     seed = 32'hfc34;
	pipe_word_t exp_q [$];                              // Expected host words

	acoustics_top #(
		.SCLK_HALF    (SCLK_HALF),
		.STORE_DEPTH  (STORE_DEPTH),
		.RECALL_DEPTH (RECALL_DEPTH),
		.BLOCK_WORDS  (BLOCK_WORDS)
	) dut (
		.okClk      (okClk),
		.reset_sclk (reset_sclk),
		.collect_en (collect_en),
		.read_en    (read_en),
		.clear      (clear),
		.drdy_in    (drdy_in),
		.miso_pf_in (miso_pf_in),
		.miso_pa_in (miso_pa_in),
		.miso_sf_in (miso_sf_in),
		.miso_sa_in (miso_sa_in),
		.sclk_out   (sclk_out),
		.start      (start),
		.pipe_read  (pipe_read),
		.pipe_data  (pipe_data),
		.pipe_ready (pipe_ready)
	);

	always #10 okClk = ~okClk;                          // 20 ns period

	// ----------------------------------------------------------
	// ADC model drives the next MSB after each sclk rise
	// ----------------------------------------------------------
	always @(posedge okClk) begin
		sclk_d <= sclk_out;
		if (sclk_out && !sclk_d) begin
			miso_pf_in <= cur_pf[bit_idx];
			miso_pa_in <= cur_pa[bit_idx];
			miso_sf_in <= cur_sf[bit_idx];
			miso_sa_in <= cur_sa[bit_idx];
			bit_idx <= (bit_idx == 0) ? SAMPLE_BITS - 1 : bit_idx - 1; // 24 rises per sample
		end
	end

	initial begin
		repeat (WATCH_CYCLES) @(posedge okClk);
		$display("Run timed out after %0d clock cycles", WATCH_CYCLES);
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_word(input string name, input pipe_word_t got, input pipe_word_t exp);
		if (got !== exp) begin
			stop_with_error($sformatf("mismatch at %0t ns: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_with_error($sformatf("mismatch at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
		end
	endtask

	// ----------------------------------------------------------
	// Stimulus helpers
	// ----------------------------------------------------------
	task automatic build_table();
		logic [31:0] rnd;
		tab_pf[0] = 24'habcdef;                         // Fixed patterns first
		tab_pa[0] = 24'h123456;
		tab_sf[0] = 24'h800001;
		tab_sa[0] = 24'hfedcba;
		tab_pf[1] = 24'hffffff;
		tab_pa[1] = 24'h000000;
		tab_sf[1] = 24'haaaaaa;
		tab_sa[1] = 24'h555555;
		tab_pf[2] = 24'h000001;
		tab_pa[2] = 24'h800000;
		tab_sf[2] = 24'h0f0f0f;
		tab_sa[2] = 24'hf0f0f0;
		for (int r = 3; r < ROWS; r++) begin
			rnd = $random(seed);
			tab_pf[r] = rnd[23:0];
			rnd = $random(seed);
			tab_pa[r] = rnd[23:0];
			rnd = $random(seed);
			tab_sf[r] = rnd[23:0];
			rnd = $random(seed);
			tab_sa[r] = rnd[23:0];
		end
		for (int r = 0; r < ROWS; r++) begin
			tab_mode[r] = MODE_PLAIN;
			tab_read[r] = (r == 1) || (r == 3) || (r == 5) || (r == 8); // Pairs fill a block
		end
		tab_mode[4] = MODE_GLITCH;
		tab_mode[6] = MODE_CLEAR;                       // Row lost to the clear
	endtask

	// Frame is pad, pf, pa, sf, sa from the top; low word leaves first
	task automatic push_expected(input int r);
		frame_t f;
		f = {32'h0, tab_pf[r], tab_pa[r], tab_sf[r], tab_sa[r]};
		for (int w = 0; w < WORDS_PER_FRAME; w++) begin
			exp_q.push_back(f[w*PIPE_BITS +: PIPE_BITS]);
		end
	endtask

	task automatic set_collect(input logic level);
		@(posedge okClk);
		collect_en <= level;
		@(negedge okClk);
		check_flag("start", start, level);
	endtask

	task automatic apply_row(input int r);
		int low_cnt;
		low_cnt = 0;
		@(posedge okClk);
		cur_pf <= tab_pf[r];
		cur_pa <= tab_pa[r];
		cur_sf <= tab_sf[r];
		cur_sa <= tab_sa[r];
		drdy_in <= 1'b0;                                // Sample ready
		repeat (4) @(posedge okClk);
		drdy_in <= 1'b1;
		do @(negedge okClk); while (sclk_out !== 1'b1); // Transfer running
		if (tab_mode[r] == MODE_GLITCH) begin
			repeat (10) @(posedge okClk);
			drdy_in <= 1'b0;                            // Must be ignored
			repeat (4) @(posedge okClk);
			drdy_in <= 1'b1;
		end
		while (low_cnt < 8) begin
			@(negedge okClk);
			low_cnt = sclk_out ? 0 : low_cnt + 1;
		end
		if (tab_mode[r] == MODE_CLEAR) begin
			@(posedge okClk);
			clear <= 1'b1;                              // Empties both FIFOs
			@(posedge okClk);
			clear <= 1'b0;
		end else begin
			push_expected(r);
		end
		if (read_en) begin                              // High only with a whole block
			@(negedge okClk);
			check_flag("pipe_ready", pipe_ready, exp_q.size() >= BLOCK_WORDS);
		end
	endtask

	task automatic read_block();
		if (!read_en) begin
			repeat (20) begin                           // Frames parked in storage
				@(negedge okClk);
				check_flag("pipe_ready", pipe_ready, 1'b0);
			end
			@(posedge okClk);
			read_en <= 1'b1;
		end
		do @(negedge okClk); while (pipe_ready !== 1'b1);
		for (int i = 0; i < BLOCK_WORDS; i++) begin
			@(negedge okClk);
			if (exp_q.size() == 0) begin
				stop_with_error("Host read a word that no captured row accounts for");
			end else begin
				check_word("pipe_data", pipe_data, exp_q.pop_front());
				@(posedge okClk);
				pipe_read <= 1'b1;                      // One-cycle strobe
				@(posedge okClk);
				pipe_read <= 1'b0;
			end
		end
	endtask

	// ----------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------
	initial begin
		build_table();
		repeat (3) @(posedge okClk);
		reset_sclk <= 1'b0;
		repeat (16) begin                               // Quiet after reset
			@(negedge okClk);
			check_flag("pipe_ready", pipe_ready, 1'b0);
			check_flag("sclk_out", sclk_out, 1'b0);
			check_flag("start", start, 1'b0);
		end
		set_collect(1'b1);
		set_collect(1'b0);
		set_collect(1'b1);
		for (int r = 0; r < ROWS; r++) begin
			apply_row(r);
			if (tab_read[r]) begin
				read_block();
			end
		end
		@(negedge okClk);
		check_flag("pipe_ready", pipe_ready, 1'b0);
		if (exp_q.size() != 0) begin
			stop_with_error("Expected words were never delivered to the host");
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- acoustics.f
acoustics_pkg.sv
sample_fifo.sv
adc_capture.sv
frame_unpacker.sv
pipe_out_buffer.sv
acoustics_top.sv
tb_acoustics.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the acoustics testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_acoustics \
	-f acoustics.f \
	-o sim_acoustics

status=0
./obj_dir/sim_acoustics > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log || [ "$status" -ne 0 ]; then
	echo "Simulation FAILED"
	exit 1
fi

echo "Simulation passed"
exit 0
